/* hw/ghash_pkg.sv */
package ghash_pkg;

    // Width of one GHASH block and of the running hash
    localparam int NB_BLOCK = 128;

    // Blocks carried in one beat
    localparam int N_BLOCKS = 2;

    // One power of H per block position in a beat
    localparam int N_H_POW = N_BLOCKS;

    // Power counter in the key table, counts 0 to N_H_POW
    localparam int NB_POW_CNT = 2;

    // Reflected GCM reduction constant for x^128 + x^7 + x^2 + x + 1
    // GCM bit 0 is the vector MSB, so the constant lands in the top byte
    localparam logic [NB_BLOCK-1:0] GF_POLY_R = {8'he1, 120'd0};

    typedef logic [NB_BLOCK-1:0] ghash_block_t;

    // One input beat
    // Block 0 comes first in message order
    typedef struct packed {
        ghash_block_t [N_BLOCKS-1:0] blocks;
        // Beat strobe
        logic                        valid;
        // First beat of a message
        logic                        sop;
        // Block 1 absent in this beat
        logic                        skip_high;
    } ghash_beat_t;

    // Precomputed powers of the hash subkey
    // Entry 0 is H, entry 1 is H^2
    typedef struct packed {
        ghash_block_t [N_H_POW-1:0] pow;
    } h_powers_t;

endpackage

/* hw/gf128_mult.sv */
`timescale 1ns/1ps

// GF(2^128) multiply in the GCM bit-reflected convention
// Purely combinational, one shift-and-add step per bit of i_a
module gf128_mult (
    input  ghash_pkg::ghash_block_t i_a,
    input  ghash_pkg::ghash_block_t i_b,
    output ghash_pkg::ghash_block_t o_p
);
    import ghash_pkg::*;

    // Partial sums, entry k holds the result after k bits of i_a
    ghash_block_t z_chain [NB_BLOCK+1];

    // i_b times x^k, reduced, for every step that still needs it
    ghash_block_t v_chain [NB_BLOCK];

    assign z_chain[0] = '0;
    assign v_chain[0] = i_b;

    for (genvar i = 0; i < NB_BLOCK; i++) begin : g_step
        // GCM bit i of i_a sits at vector position NB_BLOCK-1-i
        assign z_chain[i+1] = i_a[NB_BLOCK-1-i] ? (z_chain[i] ^ v_chain[i]) : z_chain[i];

        // Last step has no use for a further shifted multiplicand
        if (i < NB_BLOCK - 1) begin : g_shift
            // Multiply by x, folding the x^127 coefficient back in
            assign v_chain[i+1] = v_chain[i][0] ? ((v_chain[i] >> 1) ^ GF_POLY_R)
                                                : (v_chain[i] >> 1);
        end
    end

    assign o_p = z_chain[NB_BLOCK];

endmodule

/* hw/h_key_power_table.sv */
`timescale 1ns/1ps

// Key power table
// Loads H on a pulse, then builds H^2 .. H^N_H_POW one power per cycle
module h_key_power_table (
    input  logic                    clock,
    input  logic                    i_reset,
    input  logic                    i_key_load,
    input  ghash_pkg::ghash_block_t i_h_key,
    output ghash_pkg::h_powers_t    o_h_powers,
    output logic                    o_key_ready
);
    import ghash_pkg::*;

    h_powers_t             powers_q;
    logic [NB_POW_CNT-1:0] pow_cnt_q;
    logic                  key_ready_q;
    logic                  busy;
    ghash_block_t          last_pow;
    ghash_block_t          next_pow;

    // Counter holds the number of powers already in the table
    // Zero means nothing loaded since reset
    assign busy = (pow_cnt_q != '0) && (pow_cnt_q < NB_POW_CNT'(N_H_POW));

    // Highest power written so far
    always_comb begin
        last_pow = powers_q.pow[0];
        for (int k = 1; k < N_H_POW; k++) begin
            if (pow_cnt_q == NB_POW_CNT'(k + 1)) begin
                last_pow = powers_q.pow[k];
            end
        end
    end

    // Next power is last power times H
    gf128_mult u_pow_mult (
        .i_a (last_pow),
        .i_b (powers_q.pow[0]),
        .o_p (next_pow)
    );

    // Counter and ready flag
    always_ff @(posedge clock) begin
        if (i_reset) begin
            pow_cnt_q   <= '0;
            key_ready_q <= 1'b0;
        end else if (i_key_load) begin
            // A new key restarts the sequence and drops ready
            pow_cnt_q   <= NB_POW_CNT'(1);
            key_ready_q <= 1'b0;
        end else if (busy) begin
            pow_cnt_q   <= pow_cnt_q + 1'b1;
            // Ready together with the last power write
            key_ready_q <= (pow_cnt_q == NB_POW_CNT'(N_H_POW - 1));
        end
    end

    // Power storage
    always_ff @(posedge clock) begin
        if (i_key_load) begin
            powers_q.pow[0] <= i_h_key;
        end else if (busy) begin
            for (int k = 1; k < N_H_POW; k++) begin
                if (pow_cnt_q == NB_POW_CNT'(k)) begin
                    powers_q.pow[k] <= next_pow;
                end
            end
        end
    end

    assign o_h_powers  = powers_q;
    assign o_key_ready = key_ready_q;

endmodule

/* hw/ghash_two_block.sv */
`timescale 1ns/1ps

// Two-block GHASH engine
// Folds one beat per cycle into the running hash:
//   Y' = (S ^ X0) * H^2 ^ X1 * H    both blocks present
//   Y' = (S ^ X0) * H               skip_high set
// S is i_initial on sop and the current hash otherwise
module ghash_two_block (
    input  logic                    clock,
    input  logic                    i_reset,
    input  ghash_pkg::ghash_beat_t  i_beat,
    input  ghash_pkg::ghash_block_t i_initial,
    input  ghash_pkg::h_powers_t    i_h_powers,
    output ghash_pkg::ghash_block_t o_hash,
    output logic                    o_hash_valid
);
    import ghash_pkg::*;

    ghash_block_t hash_q;
    logic         hash_valid_q;

    ghash_block_t block_low;
    ghash_block_t block_high;
    ghash_block_t start_val;
    ghash_block_t low_mix;
    ghash_block_t low_pow;
    ghash_block_t low_prod;
    ghash_block_t high_prod;
    ghash_block_t high_term;
    ghash_block_t hash_next;

    assign block_low  = i_beat.blocks[0];
    assign block_high = i_beat.blocks[1];

    // Restart from the supplied start value on the first beat
    assign start_val = i_beat.sop ? i_initial : hash_q;

    assign low_mix = start_val ^ block_low;

    // Low block is the last one in the beat when the high block is absent,
    // so it only needs a single power of H then
    assign low_pow = i_beat.skip_high ? i_h_powers.pow[0] : i_h_powers.pow[1];

    gf128_mult u_low_mult (
        .i_a (low_mix),
        .i_b (low_pow),
        .o_p (low_prod)
    );

    // High block always pairs with H
    gf128_mult u_high_mult (
        .i_a (block_high),
        .i_b (i_h_powers.pow[0]),
        .o_p (high_prod)
    );

    // Drop the high block contribution when it is not part of the message
    assign high_term = i_beat.skip_high ? '0 : high_prod;

    assign hash_next = low_prod ^ high_term;

    // Hash register holds across invalid cycles
    always_ff @(posedge clock) begin
        if (i_reset) begin
            hash_q       <= '0;
            hash_valid_q <= 1'b0;
        end else begin
            hash_valid_q <= i_beat.valid;
            if (i_beat.valid) begin
                hash_q <= hash_next;
            end
        end
    end

    assign o_hash       = hash_q;
    assign o_hash_valid = hash_valid_q;

endmodule

/* hw/ghash_top.sv */
`timescale 1ns/1ps

// GHASH accumulator top
// Key power table feeding the two-block engine, no extra pipeline
module ghash_top (
    input  logic                    clock,
    input  logic                    i_reset,
    input  logic                    i_key_load,
    input  ghash_pkg::ghash_block_t i_h_key,
    input  ghash_pkg::ghash_beat_t  i_beat,
    input  ghash_pkg::ghash_block_t i_initial,
    output logic                    o_key_ready,
    output ghash_pkg::ghash_block_t o_hash,
    output logic                    o_hash_valid
);
    import ghash_pkg::*;

    // H and H^2 from the table
    h_powers_t h_powers;

    h_key_power_table u_key_table (
        .clock       (clock),
        .i_reset     (i_reset),
        .i_key_load  (i_key_load),
        .i_h_key     (i_h_key),
        .o_h_powers  (h_powers),
        .o_key_ready (o_key_ready)
    );

    // Engine trusts the user to hold valid low until the key is ready
    ghash_two_block u_engine (
        .clock        (clock),
        .i_reset      (i_reset),
        .i_beat       (i_beat),
        .i_initial    (i_initial),
        .i_h_powers   (h_powers),
        .o_hash       (o_hash),
        .o_hash_valid (o_hash_valid)
    );

endmodule

/* sim/ghash_top_assert.sv */
`timescale 1ns/1ps

// Protocol and timing checks on the GHASH top level
module ghash_top_assert (
    input logic                    clock,
    input logic                    i_reset,
    input logic                    i_key_load,
    input ghash_pkg::ghash_beat_t  i_beat,
    input logic                    o_key_ready,
    input ghash_pkg::ghash_block_t o_hash,
    input logic                    o_hash_valid
);
    import ghash_pkg::*;

    // One tally per property
    int reset_fails   = 0;
    int drop_fails    = 0;
    int rise_fails    = 0;
    int early_fails   = 0;
    int pulse_fails   = 0;
    int idle_fails    = 0;
    int hold_fails    = 0;
    int unready_fails = 0;
    int fail_count;

    logic beat_valid;

    assign beat_valid = i_beat.valid;

    assign fail_count = reset_fails + drop_fails + rise_fails + early_fails
                      + pulse_fails + idle_fails + hold_fails + unready_fails;

    // Outputs cleared by reset
    a_reset_state: assert property (@(posedge clock)
        i_reset |=> (!o_key_ready && !o_hash_valid && (o_hash == '0)))
        else begin
            reset_fails++;
            $error("outputs not cleared one cycle after reset");
        end

    // A load, even while ready, drops ready on the next cycle
    a_ready_drop: assert property (@(posedge clock) disable iff (i_reset)
        i_key_load |=> !o_key_ready)
        else begin
            drop_fails++;
            $error("o_key_ready high one cycle after a key load");
        end

    // Ready two cycles after an isolated load
    a_ready_rise: assert property (@(posedge clock) disable iff (i_reset)
        ($past(i_key_load, 2) && !$past(i_key_load) && !$past(i_reset)
         && !$past(i_reset, 2)) |-> o_key_ready)
        else begin
            rise_fails++;
            $error("o_key_ready not high two cycles after a key load");
        end

    // Never rises without the load two cycles back
    a_ready_not_early: assert property (@(posedge clock) disable iff (i_reset)
        $rose(o_key_ready) |-> $past(i_key_load, 2))
        else begin
            early_fails++;
            $error("o_key_ready rose at the wrong time after a key load");
        end

    a_valid_pulse: assert property (@(posedge clock) disable iff (i_reset)
        beat_valid |=> o_hash_valid)
        else begin
            pulse_fails++;
            $error("o_hash_valid missing one cycle after a valid beat");
        end

    a_valid_idle: assert property (@(posedge clock) disable iff (i_reset)
        !beat_valid |=> !o_hash_valid)
        else begin
            idle_fails++;
            $error("o_hash_valid high after an idle cycle");
        end

    // Hash holds across invalid cycles
    a_hash_hold: assert property (@(posedge clock) disable iff (i_reset)
        !beat_valid |=> $stable(o_hash))
        else begin
            hold_fails++;
            $error("o_hash changed after an idle cycle");
        end

    a_no_beat_unready: assert property (@(posedge clock) disable iff (i_reset)
        beat_valid |-> o_key_ready)
        else begin
            unready_fails++;
            $error("valid beat while o_key_ready is low");
        end

endmodule

bind ghash_top ghash_top_assert u_assert (
    .clock        (clock),
    .i_reset      (i_reset),
    .i_key_load   (i_key_load),
    .i_beat       (i_beat),
    .o_key_ready  (o_key_ready),
    .o_hash       (o_hash),
    .o_hash_valid (o_hash_valid)
);

/* sim/tb_ghash_top.sv */
`timescale 1ns/1ps

module tb_ghash_top;
    import ghash_pkg::*;

    // Hash subkey of the all-zero AES key
    localparam ghash_block_t KNOWN_H  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
    // GCM test case 2 with one ciphertext block and its length block
    localparam ghash_block_t KAT_C    = 128'h0388dace60b6a392f328c2b971b2fe78;
    localparam ghash_block_t KAT_LEN  = 128'h00000000000000000000000000000080;
    localparam ghash_block_t KAT_HASH = 128'hf38cbb1ad69223dcc3457ae5b6b0f885;
    localparam int WAIT_LIMIT = 20;

    logic         clock;
    logic         i_reset;
    logic         i_key_load;
    ghash_block_t i_h_key;
    ghash_beat_t  i_beat;
    ghash_block_t i_initial;
    logic         o_key_ready;
    ghash_block_t o_hash;
    logic         o_hash_valid;

    logic [31:0]  lcg_state;
    ghash_block_t model_h;
    ghash_block_t model_h2;
    ghash_block_t model_hash;
    ghash_block_t expected_q [$];
    int           hash_errors;
    int           timeouts;
    int           hashes_checked;

    ghash_top ghash_top_i (
        .clock        (clock),
        .i_reset      (i_reset),
        .i_key_load   (i_key_load),
        .i_h_key      (i_h_key),
        .i_beat       (i_beat),
        .i_initial    (i_initial),
        .o_key_ready  (o_key_ready),
        .o_hash       (o_hash),
        .o_hash_valid (o_hash_valid)
    );

    always #20 clock = ~clock;

    // Bit-serial product in GCM order with bit 0 at the vector MSB
    function automatic ghash_block_t gf_mul_serial(input ghash_block_t x, input ghash_block_t y);
        ghash_block_t z;
        ghash_block_t v;
        z = '0;
        v = y;
        for (int i = 0; i < 128; i++) begin
            if (x[127 - i]) begin
                z = z ^ v;
            end
            if (v[0]) begin
                v = (v >> 1) ^ {8'he1, 120'd0};
            end else begin
                v = v >> 1;
            end
        end
        return z;
    endfunction

    // Expected hash after one beat
    function automatic ghash_block_t model_beat(input ghash_block_t start, input ghash_block_t x0,
                                               input ghash_block_t x1, input logic skip);
        ghash_block_t mix;
        ghash_block_t result;
        mix = start ^ x0;
        if (skip) begin
            result = gf_mul_serial(mix, model_h);
        end else begin
            result = gf_mul_serial(mix, model_h2) ^ gf_mul_serial(x1, model_h);
        end
        return result;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper LCG bits only since the low ones cycle too fast
    function automatic int rand_below(input int n);
        return int'(lcg_next() >> 16) % n;
    endfunction

    function automatic ghash_block_t rand_block();
        ghash_block_t b;
        for (int i = 0; i < 4; i++) begin
            b[32*i +: 32] = lcg_next();
        end
        return b;
    endfunction

    task automatic finish_run();
        int assert_fails;
        assert_fails = ghash_top_i.u_assert.fail_count;
        $display("Summary: %0d hash errors, %0d assertion failures, %0d timeouts, %0d hashes checked",
                 hash_errors, assert_fails, timeouts, hashes_checked);
        if (hash_errors + assert_fails + timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // Step to the next falling edge and check any hash that came out
    task automatic next_cycle();
        ghash_block_t expected;
        @(negedge clock);
        if (o_hash_valid) begin
            assert (expected_q.size() != 0) else begin
                $display("Hash valid pulse arrived with no beat outstanding");
                hash_errors++;
            end
            if (expected_q.size() != 0) begin
                expected = expected_q.pop_front();
                hashes_checked++;
                assert (o_hash == expected) else begin
                    $display("ERROR: o_hash expected %h got %h", expected, o_hash);
                    hash_errors++;
                end
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic send_beat(input ghash_block_t x0, input ghash_block_t x1,
                             input logic sop, input logic skip, input ghash_block_t init);
        ghash_beat_t  beat;
        ghash_block_t start;
        start = sop ? init : model_hash;
        model_hash = model_beat(start, x0, x1, skip);
        expected_q.push_back(model_hash);
        beat.blocks[0] = x0;
        beat.blocks[1] = x1;
        beat.valid     = 1'b1;
        beat.sop       = sop;
        beat.skip_high = skip;
        i_beat    = beat;
        i_initial = init;
        next_cycle();
        i_beat.valid = 1'b0;
    endtask

    task automatic wait_key_ready();
        int n;
        n = 0;
        while (!o_key_ready && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!o_key_ready) begin
            $display("Timeout: o_key_ready still low %0d cycles after a key load", WAIT_LIMIT);
            timeouts++;
            finish_run();
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (expected_q.size() != 0 && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (expected_q.size() != 0) begin
            $display("Timeout: %0d hash results never arrived", expected_q.size());
            timeouts++;
            finish_run();
        end
    endtask

    task automatic load_key(input ghash_block_t h);
        i_key_load = 1'b1;
        i_h_key    = h;
        model_h    = h;
        model_h2   = gf_mul_serial(h, h);
        next_cycle();
        i_key_load = 1'b0;
        // Key input is ignored outside the pulse
        i_h_key    = rand_block();
        wait_key_ready();
    endtask

    // Random messages with random length, gaps and a skipped last high block
    task automatic run_messages(input int count);
        int           n_beats;
        logic         skip_last;
        logic         skip;
        ghash_block_t x0;
        ghash_block_t x1;
        ghash_block_t init;
        for (int m = 0; m < count; m++) begin
            n_beats   = 1 + rand_below(4);
            skip_last = (rand_below(2) == 1);
            for (int b = 0; b < n_beats; b++) begin
                skip = (b == n_beats - 1) && skip_last;
                x0   = rand_block();
                x1   = rand_block();
                init = rand_block();
                send_beat(x0, x1, b == 0, skip, init);
                if (rand_below(3) == 0) begin
                    idle_cycles(1 + rand_below(2));
                end
            end
        end
    endtask

    initial begin
        ghash_block_t kat_model;
        clock          = 1'b0;
        i_reset        = 1'b1;
        i_key_load     = 1'b0;
        i_h_key        = '0;
        i_beat         = '0;
        i_initial      = '0;
        lcg_state      = 32'hf76c0939;
        model_h        = '0;
        model_h2       = '0;
        model_hash     = '0;
        hash_errors    = 0;
        timeouts       = 0;
        hashes_checked = 0;

        repeat (2) @(posedge clock);
        @(negedge clock);
        i_reset = 1'b0;
        idle_cycles(2);

        load_key(KNOWN_H);

        // Model against the published vector first
        kat_model = model_beat('0, KAT_C, KAT_LEN, 1'b0);
        assert (kat_model == KAT_HASH) else begin
            $display("Reference model disagrees with the GCM test vector");
            hash_errors++;
        end
        send_beat(KAT_C, KAT_LEN, 1'b1, 1'b0, '0);
        idle_cycles(1);

        run_messages(20);

        // Single-beat messages with sop on consecutive cycles
        for (int i = 0; i < 4; i++) begin
            send_beat(rand_block(), rand_block(), 1'b1, i[0], rand_block());
        end
        idle_cycles(2);

        // New key while ready, then more traffic on the new powers
        load_key(rand_block());
        run_messages(20);

        wait_drain();
        idle_cycles(2);
        finish_run();
    end

endmodule

/* verilog.f */
hw/ghash_pkg.sv
hw/gf128_mult.sv
hw/h_key_power_table.sv
hw/ghash_two_block.sv
hw/ghash_top.sv
sim/ghash_top_assert.sv
sim/tb_ghash_top.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ghash_top \
		-Mdir obj_dir -f verilog.f
	./obj_dir/Vtb_ghash_top +verilator+error+limit+1000 | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
